// File: common/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry, 2-way, 8 sets, 2 words per block
`define DC_SETS 8             // sets per way
`define DC_WAYS 2             // ways per set
`define DC_WORD_W 32          // data and address width
`define DC_BLOCK_WORDS 2      // words per block

// address split: tag | index | block offset | byte offset
`define DC_IDX_W 3            // log2 of DC_SETS
`define DC_TAG_W 26           // what is left above index and offsets
`define DC_FLUSH_ADDR_LSB 2   // byte offset bits, always zero on the bus

`endif

// File: common/dcache_geom_pkg.sv
`include "dcache_cfg.svh"

package dcache_geom_pkg;

  typedef logic [`DC_WORD_W-1:0] word_t;  // one data word
  typedef logic [`DC_TAG_W-1:0]  tag_t;   // tag field
  typedef logic [`DC_IDX_W-1:0]  index_t; // set index

  // way number, 1 bit for two ways
  typedef logic [$clog2(`DC_WAYS)-1:0] way_sel_t;

  // processor byte address
  typedef struct packed {
    tag_t                                 tag;
    index_t                               idx;
    logic [$clog2(`DC_BLOCK_WORDS)-1:0]   blkoff;  // word within block
    logic [`DC_FLUSH_ADDR_LSB-1:0]        bytoff;  // byte within word
  } dc_addr_t;

  // one stored line, 92 bits
  typedef struct packed {
    tag_t                          tag;
    word_t [`DC_BLOCK_WORDS-1:0]   block;  // block[0] is the low word
    logic                          valid;
    logic                          dirty;  // at least one word differs from memory
  } line_t;

endpackage

// File: common/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

  // controller states
  typedef enum logic [3:0] {
    IDLE,       // lookup, hits answered here
    WB0,        // victim low word to memory
    WB1,        // victim high word to memory
    FILL0,      // fetch low word
    FILL1,      // fetch high word
    FLUSH_W0L,  // flush way 0 low word
    FLUSH_W0H,
    FLUSH_W1L,
    FLUSH_W1H,  // last step of a set, index moves on
    FLUSHED     // array empty, parked until reset
  } dc_state_e;

  // write commands into the array
  typedef enum logic [2:0] {
    NONE,
    HIT_WRITE,  // processor word into hit way, set dirty
    FILL_WORD,  // fetched word into victim, valid low
    FILL_LAST,  // last fetched word, valid high
    CLEAN,      // victim written back, drop dirty
    CLEAR_ALL   // invalidate every line
  } arr_cmd_e;

endpackage

// File: dcache/dcache_array.sv
`include "dcache_cfg.svh"

module dcache_array (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      dmemREN,
  input  logic                      dmemWEN,
  input  dcache_geom_pkg::dc_addr_t dmemaddr,
  input  dcache_geom_pkg::word_t    dmemstore,
  input  dcache_ctrl_pkg::arr_cmd_e arr_cmd,
  input  logic                      arr_word_sel,
  input  dcache_geom_pkg::word_t    arr_wdata,
  input  dcache_geom_pkg::index_t   flush_index,
  output logic                      hit,
  output dcache_geom_pkg::word_t    dmemload,
  output logic                      victim_dirty,
  output dcache_geom_pkg::tag_t     victim_tag,
  output dcache_geom_pkg::word_t    victim_word0,
  output dcache_geom_pkg::word_t    victim_word1,
  output dcache_geom_pkg::line_t    flush_line_w0,
  output dcache_geom_pkg::line_t    flush_line_w1
);

  // tag and data storage
  dcache_geom_pkg::tag_t     tag_q  [`DC_WAYS][`DC_SETS];
  dcache_geom_pkg::word_t    data_q [`DC_WAYS][`DC_SETS][`DC_BLOCK_WORDS];
  // line state
  logic                      valid_q [`DC_WAYS][`DC_SETS];
  logic                      dirty_q [`DC_WAYS][`DC_SETS];
  dcache_geom_pkg::way_sel_t lru_q   [`DC_SETS];  // way to evict next

  dcache_geom_pkg::index_t   idx;
  dcache_geom_pkg::way_sel_t hit_way;
  dcache_geom_pkg::way_sel_t victim;
  logic [`DC_WAYS-1:0]       way_hit;
  logic                      req;

  assign idx    = dmemaddr.idx;
  assign req    = dmemREN | dmemWEN;  // no lookup without a request
  assign victim = lru_q[idx];

  // tag compare on every way of the addressed set
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = req && valid_q[w][idx] && (tag_q[w][idx] == dmemaddr.tag);
      if (way_hit[w]) hit_way = dcache_geom_pkg::way_sel_t'(w);
    end
  end

  assign hit      = |way_hit;
  assign dmemload = hit ? data_q[hit_way][idx][dmemaddr.blkoff] : '0;

  // victim description for write-back
  assign victim_dirty = valid_q[victim][idx] && dirty_q[victim][idx];
  assign victim_tag   = tag_q[victim][idx];
  assign victim_word0 = data_q[victim][idx][0];
  assign victim_word1 = data_q[victim][idx][1];

  // both lines of the set under flush
  always_comb begin
    flush_line_w0.tag   = tag_q[0][flush_index];
    flush_line_w0.valid = valid_q[0][flush_index];
    flush_line_w0.dirty = dirty_q[0][flush_index];
    flush_line_w1.tag   = tag_q[1][flush_index];
    flush_line_w1.valid = valid_q[1][flush_index];
    flush_line_w1.dirty = dirty_q[1][flush_index];
    for (int b = 0; b < `DC_BLOCK_WORDS; b++) begin
      flush_line_w0.block[b] = data_q[0][flush_index][b];
      flush_line_w1.block[b] = data_q[1][flush_index][b];
    end
  end

  // payload write port
  always_ff @(posedge CLK) begin
    case (arr_cmd)
      dcache_ctrl_pkg::HIT_WRITE: begin
        if (hit) data_q[hit_way][idx][dmemaddr.blkoff] <= dmemstore;
      end
      dcache_ctrl_pkg::FILL_WORD, dcache_ctrl_pkg::FILL_LAST: begin
        tag_q[victim][idx]                <= dmemaddr.tag;  // new owner of the line
        data_q[victim][idx][arr_word_sel] <= arr_wdata;
      end
      default: ;
    endcase
  end

  // valid, dirty and lru
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        lru_q[s] <= '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
          valid_q[w][s] <= 1'b0;
          dirty_q[w][s] <= 1'b0;
        end
      end
    end else begin
      if (hit) lru_q[idx] <= ~hit_way;  // the way not hit goes next
      case (arr_cmd)
        dcache_ctrl_pkg::HIT_WRITE: begin
          if (hit) dirty_q[hit_way][idx] <= 1'b1;
        end
        dcache_ctrl_pkg::FILL_WORD: begin
          valid_q[victim][idx] <= 1'b0;  // half a block is not usable yet
          dirty_q[victim][idx] <= 1'b0;
        end
        dcache_ctrl_pkg::FILL_LAST: begin
          valid_q[victim][idx] <= 1'b1;
          dirty_q[victim][idx] <= 1'b0;
        end
        dcache_ctrl_pkg::CLEAN: dirty_q[victim][idx] <= 1'b0;
        dcache_ctrl_pkg::CLEAR_ALL: begin
          for (int s = 0; s < `DC_SETS; s++) begin
            lru_q[s] <= '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
              valid_q[w][s] <= 1'b0;
              dirty_q[w][s] <= 1'b0;
            end
          end
        end
        default: ;
      endcase
    end
  end

  // fills only go to a missing block, so one address lives in one way at most
  a_one_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0(way_hit));

endmodule

// File: dcache/dcache_ctrl.sv
`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      dmemREN,
  input  logic                      dmemWEN,
  input  logic                      halt,
  input  logic                      hit,
  input  dcache_geom_pkg::dc_addr_t dmemaddr,
  input  dcache_geom_pkg::word_t    dmemstore,
  input  logic                      victim_dirty,
  input  dcache_geom_pkg::tag_t     victim_tag,
  input  dcache_geom_pkg::word_t    victim_word0,
  input  dcache_geom_pkg::word_t    victim_word1,
  input  dcache_geom_pkg::line_t    flush_line_w0,
  input  dcache_geom_pkg::line_t    flush_line_w1,
  input  dcache_geom_pkg::word_t    wb_dat_i,
  input  logic                      wb_ack,
  output dcache_ctrl_pkg::arr_cmd_e arr_cmd,
  output logic                      arr_word_sel,
  output dcache_geom_pkg::word_t    arr_wdata,
  output dcache_geom_pkg::index_t   flush_index,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output dcache_geom_pkg::word_t    wb_adr,
  output dcache_geom_pkg::word_t    wb_dat_o,
  output logic                      flushed
);

  dcache_ctrl_pkg::dc_state_e state_q, state_d;
  dcache_geom_pkg::index_t    flush_idx_q;
  dcache_geom_pkg::line_t     flush_line;
  dcache_geom_pkg::dc_addr_t  bus_addr;
  logic                       req;
  logic                       miss_busy;
  logic                       flush_way;   // 0: way 0, 1: way 1
  logic                       flush_word;  // 0: low word, 1: high word
  logic                       step_dirty;
  logic                       flush_inc;

  assign req       = dmemREN | dmemWEN;
  assign miss_busy = state_q inside {dcache_ctrl_pkg::WB0, dcache_ctrl_pkg::WB1,
                                     dcache_ctrl_pkg::FILL0, dcache_ctrl_pkg::FILL1};

  // flush step decode
  assign flush_way  = state_q inside {dcache_ctrl_pkg::FLUSH_W1L, dcache_ctrl_pkg::FLUSH_W1H};
  assign flush_word = state_q inside {dcache_ctrl_pkg::FLUSH_W0H, dcache_ctrl_pkg::FLUSH_W1H};
  assign flush_line = flush_way ? flush_line_w1 : flush_line_w0;
  assign step_dirty = flush_line.valid && flush_line.dirty;  // clean words skip the bus

  always_comb begin
    state_d      = state_q;
    arr_cmd      = dcache_ctrl_pkg::NONE;
    arr_word_sel = 1'b0;
    wb_cyc       = 1'b0;
    wb_we        = 1'b0;
    wb_dat_o     = '0;
    bus_addr     = '0;  // byte offset stays zero
    flush_inc    = 1'b0;

    case (state_q)
      dcache_ctrl_pkg::IDLE: begin
        if (halt) begin
          state_d = dcache_ctrl_pkg::FLUSH_W0L;
        end else if (req && !hit) begin
          state_d = victim_dirty ? dcache_ctrl_pkg::WB0 : dcache_ctrl_pkg::FILL0;
        end else if (dmemWEN && hit) begin
          arr_cmd = dcache_ctrl_pkg::HIT_WRITE;  // lands at the next edge
        end
      end

      // write-back, address rebuilt from the victim tag
      dcache_ctrl_pkg::WB0: begin
        wb_cyc       = 1'b1;
        wb_we        = 1'b1;
        bus_addr.tag = victim_tag;
        bus_addr.idx = dmemaddr.idx;
        wb_dat_o     = victim_word0;
        if (wb_ack) state_d = dcache_ctrl_pkg::WB1;
      end
      dcache_ctrl_pkg::WB1: begin
        wb_cyc          = 1'b1;
        wb_we           = 1'b1;
        bus_addr.tag    = victim_tag;
        bus_addr.idx    = dmemaddr.idx;
        bus_addr.blkoff = 1'b1;
        wb_dat_o        = victim_word1;
        if (wb_ack) begin
          arr_cmd = dcache_ctrl_pkg::CLEAN;
          state_d = dcache_ctrl_pkg::FILL0;
        end
      end

      // fill, address from the pending request
      dcache_ctrl_pkg::FILL0: begin
        wb_cyc       = 1'b1;
        bus_addr.tag = dmemaddr.tag;
        bus_addr.idx = dmemaddr.idx;
        if (wb_ack) begin
          arr_cmd = dcache_ctrl_pkg::FILL_WORD;
          state_d = dcache_ctrl_pkg::FILL1;
        end
      end
      dcache_ctrl_pkg::FILL1: begin
        wb_cyc          = 1'b1;
        bus_addr.tag    = dmemaddr.tag;
        bus_addr.idx    = dmemaddr.idx;
        bus_addr.blkoff = 1'b1;
        arr_word_sel    = 1'b1;
        if (wb_ack) begin
          arr_cmd = dcache_ctrl_pkg::FILL_LAST;  // line valid, request hits in IDLE
          state_d = dcache_ctrl_pkg::IDLE;
        end
      end

      dcache_ctrl_pkg::FLUSH_W0L, dcache_ctrl_pkg::FLUSH_W0H,
      dcache_ctrl_pkg::FLUSH_W1L, dcache_ctrl_pkg::FLUSH_W1H: begin
        wb_cyc          = step_dirty;
        wb_we           = step_dirty;
        bus_addr.tag    = flush_line.tag;
        bus_addr.idx    = flush_idx_q;
        bus_addr.blkoff = flush_word;
        wb_dat_o        = flush_line.block[flush_word];
        if (!step_dirty || wb_ack) begin
          case (state_q)
            dcache_ctrl_pkg::FLUSH_W0L: state_d = dcache_ctrl_pkg::FLUSH_W0H;
            dcache_ctrl_pkg::FLUSH_W0H: state_d = dcache_ctrl_pkg::FLUSH_W1L;
            dcache_ctrl_pkg::FLUSH_W1L: state_d = dcache_ctrl_pkg::FLUSH_W1H;
            default: begin
              flush_inc = 1'b1;
              if (flush_idx_q == dcache_geom_pkg::index_t'(`DC_SETS - 1)) begin
                arr_cmd = dcache_ctrl_pkg::CLEAR_ALL;  // last set done
                state_d = dcache_ctrl_pkg::FLUSHED;
              end else begin
                state_d = dcache_ctrl_pkg::FLUSH_W0L;
              end
            end
          endcase
        end
      end

      dcache_ctrl_pkg::FLUSHED: state_d = dcache_ctrl_pkg::FLUSHED;  // only reset leaves
      default: state_d = dcache_ctrl_pkg::IDLE;
    endcase
  end

  assign wb_stb      = wb_cyc;     // single transfer per cycle
  assign wb_adr      = bus_addr;
  assign arr_wdata   = wb_dat_i;   // only read data is written by command
  assign flush_index = flush_idx_q;
  assign flushed     = (state_q == dcache_ctrl_pkg::FLUSHED);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q     <= dcache_ctrl_pkg::IDLE;
      flush_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (flush_inc) flush_idx_q <= flush_idx_q + 1'b1;  // wraps to 0 after the last set
    end
  end

  // classic handshake, master holds everything until ack
  a_bus_hold: assert property (@(posedge CLK) disable iff (!nRST)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o));

  // miss handling relies on the processor holding its request
  a_req_hold: assert property (@(posedge CLK) disable iff (!nRST)
    miss_busy |=> $stable(dmemaddr) && (!dmemWEN || $stable(dmemstore)));

endmodule

// File: dcache/dcache.sv
module dcache (
  input  logic                     CLK,
  input  logic                     nRST,
  // processor side
  input  logic                     dmemREN,
  input  logic                     dmemWEN,
  input  logic                     halt,
  input  dcache_geom_pkg::dc_addr_t dmemaddr,
  input  dcache_geom_pkg::word_t   dmemstore,
  output logic                     dhit,
  output logic                     flushed,
  output dcache_geom_pkg::word_t   dmemload,
  // wishbone classic master
  input  dcache_geom_pkg::word_t   wb_dat_i,
  input  logic                     wb_ack,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output dcache_geom_pkg::word_t   wb_adr,
  output dcache_geom_pkg::word_t   wb_dat_o
);

  // controller to array
  dcache_ctrl_pkg::arr_cmd_e arr_cmd;
  logic                      arr_word_sel;
  dcache_geom_pkg::word_t    arr_wdata;
  dcache_geom_pkg::index_t   flush_index;

  // array to controller
  logic                      hit;
  logic                      victim_dirty;
  dcache_geom_pkg::tag_t     victim_tag;
  dcache_geom_pkg::word_t    victim_word0;
  dcache_geom_pkg::word_t    victim_word1;
  dcache_geom_pkg::line_t    flush_line_w0;
  dcache_geom_pkg::line_t    flush_line_w1;

  assign dhit = hit;  // hits are answered straight from the lookup

  dcache_array u_array (
    .CLK           (CLK),
    .nRST          (nRST),
    .dmemREN       (dmemREN),
    .dmemWEN       (dmemWEN),
    .dmemaddr      (dmemaddr),
    .dmemstore     (dmemstore),
    .arr_cmd       (arr_cmd),
    .arr_word_sel  (arr_word_sel),
    .arr_wdata     (arr_wdata),
    .flush_index   (flush_index),
    .hit           (hit),
    .dmemload      (dmemload),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .victim_word0  (victim_word0),
    .victim_word1  (victim_word1),
    .flush_line_w0 (flush_line_w0),
    .flush_line_w1 (flush_line_w1)
  );

  dcache_ctrl u_ctrl (
    .CLK           (CLK),
    .nRST          (nRST),
    .dmemREN       (dmemREN),
    .dmemWEN       (dmemWEN),
    .halt          (halt),
    .hit           (hit),
    .dmemaddr      (dmemaddr),
    .dmemstore     (dmemstore),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .victim_word0  (victim_word0),
    .victim_word1  (victim_word1),
    .flush_line_w0 (flush_line_w0),
    .flush_line_w1 (flush_line_w1),
    .wb_dat_i      (wb_dat_i),
    .wb_ack        (wb_ack),
    .arr_cmd       (arr_cmd),
    .arr_word_sel  (arr_word_sel),
    .arr_wdata     (arr_wdata),
    .flush_index   (flush_index),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_o      (wb_dat_o),
    .flushed       (flushed)
  );

endmodule

// File: sim/dcache_mem_model.sv
module dcache_mem_model #(
  parameter int          WORDS = 256,    // memory depth in words
  parameter logic [31:0] SEED  = 32'd52  // wait-state generator start value
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  dcache_geom_pkg::word_t wb_adr,
  input  dcache_geom_pkg::word_t wb_wdata,  // master write data
  output dcache_geom_pkg::word_t wb_rdata,  // read data back to master
  output logic                   wb_ack
);

  localparam int IDX_W = $clog2(WORDS);

  dcache_geom_pkg::word_t mem [WORDS];
  logic [31:0]            rng_q;
  logic [31:0]            rng_d;
  logic [1:0]             wait_q;  // wait states for the current word, 0 to 3
  logic [1:0]             cnt_q;   // cycles already waited
  logic [IDX_W-1:0]       widx;

  // xorshift32 step
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  assign widx     = wb_adr[IDX_W+1:2];  // word address, byte offset dropped
  assign rng_d    = next_random(rng_q);
  assign wb_ack   = wb_cyc && wb_stb && (cnt_q == wait_q);
  assign wb_rdata = mem[widx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rng_q  <= SEED;
      wait_q <= '0;
      cnt_q  <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= (i << 2) ^ 32'hA5A5_0000;  // byte address xor fixed pattern
      end
    end else if (wb_ack) begin
      if (wb_we) mem[widx] <= wb_wdata;
      rng_q  <= rng_d;
      wait_q <= rng_d[1:0];  // new delay for the next word
      cnt_q  <= '0;
    end else if (wb_cyc && wb_stb) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: sim/dcache_tb.sv
module dcache_tb;

  localparam int          N_ENTRIES    = 19;
  localparam int          MEM_WORDS    = 256;
  localparam int          TIMEOUT      = 16 * (N_ENTRIES + 32);  // 4 words x 4 cycles per entry
  localparam int          FLUSH_WRITES = 6;  // set 1 tag 0, set 5 tags 0 and 1, two words each
  localparam logic [31:0] SEED         = 32'd52;

  logic                      CLK;
  logic                      nRST;
  logic                      dmemREN;
  logic                      dmemWEN;
  logic                      halt;
  dcache_geom_pkg::dc_addr_t dmemaddr;
  dcache_geom_pkg::word_t    dmemstore;
  dcache_geom_pkg::word_t    dmemload;
  logic                      dhit;
  logic                      flushed;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic                      wb_ack;
  dcache_geom_pkg::word_t    wb_adr;
  dcache_geom_pkg::word_t    wb_dat_o;
  dcache_geom_pkg::word_t    wb_dat_i;

  // stimulus table
  string                  t_name  [N_ENTRIES];
  logic                   t_write [N_ENTRIES];
  dcache_geom_pkg::word_t t_addr  [N_ENTRIES];
  dcache_geom_pkg::word_t t_data  [N_ENTRIES];
  dcache_geom_pkg::word_t t_exp   [N_ENTRIES];
  logic                   t_nobus [N_ENTRIES];  // 1: hit without a bus cycle, 0: miss on the bus
  int                     n_fill;

  dcache_geom_pkg::word_t shadow [MEM_WORDS];  // what memory must hold after the flush
  logic                   bus_seen;
  int                     flush_writes;
  int                     errors;
  int                     checks;

  dcache dut0 (
    .CLK(CLK), .nRST(nRST),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dhit(dhit), .flushed(flushed), .dmemload(dmemload),
    .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_o(wb_dat_o)
  );

  dcache_mem_model #(.WORDS(MEM_WORDS), .SEED(SEED)) u_mem (
    .CLK(CLK), .nRST(nRST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_wdata(wb_dat_o),
    .wb_rdata(wb_dat_i), .wb_ack(wb_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // bus activity seen by the edges of one request, and write acks while halted
  always @(posedge CLK) begin
    if (wb_cyc) bus_seen <= 1'b1;
    if (halt && wb_cyc && wb_we && wb_ack) flush_writes <= flush_writes + 1;
  end

  function automatic dcache_geom_pkg::word_t mem_rule(input dcache_geom_pkg::word_t addr);
    return addr ^ 32'hA5A5_0000;  // initial memory content
  endfunction

  function automatic int word_index(input dcache_geom_pkg::word_t addr);
    return int'(addr >> 2) % MEM_WORDS;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic add_entry(input string name, input logic wr, input dcache_geom_pkg::word_t addr,
                           input dcache_geom_pkg::word_t data, input dcache_geom_pkg::word_t exp,
                           input logic nobus);
    t_name[n_fill]  = name;
    t_write[n_fill] = wr;
    t_addr[n_fill]  = addr;
    t_data[n_fill]  = data;
    t_exp[n_fill]   = exp;
    t_nobus[n_fill] = nobus;
    n_fill++;
  endtask

  // addr = tag*64 + set*8 + word*4
  task automatic build_table();
    add_entry("cold read",       1'b0, 32'h008, '0, mem_rule(32'h008), 1'b0);
    add_entry("neighbour hit",   1'b0, 32'h00C, '0, mem_rule(32'h00C), 1'b1);
    add_entry("write hit",       1'b1, 32'h00C, 32'h1111_2222, '0, 1'b1);
    add_entry("read back",       1'b0, 32'h00C, '0, 32'h1111_2222, 1'b1);
    add_entry("lru A",           1'b0, 32'h010, '0, mem_rule(32'h010), 1'b0);
    add_entry("lru B",           1'b0, 32'h050, '0, mem_rule(32'h050), 1'b0);
    add_entry("lru A again",     1'b0, 32'h010, '0, mem_rule(32'h010), 1'b1);
    add_entry("lru C evicts B",  1'b0, 32'h090, '0, mem_rule(32'h090), 1'b0);
    add_entry("lru A kept",      1'b0, 32'h010, '0, mem_rule(32'h010), 1'b1);
    add_entry("lru B refetch",   1'b0, 32'h050, '0, mem_rule(32'h050), 1'b0);
    add_entry("write miss A",    1'b1, 32'h018, 32'hDEAD_BEEF, '0, 1'b0);
    add_entry("evict fill B",    1'b0, 32'h058, '0, mem_rule(32'h058), 1'b0);
    add_entry("evict dirty A",   1'b0, 32'h098, '0, mem_rule(32'h098), 1'b0);
    add_entry("refetch A",       1'b0, 32'h018, '0, 32'hDEAD_BEEF, 1'b0);
    add_entry("refetch A high",  1'b0, 32'h01C, '0, mem_rule(32'h01C), 1'b1);
    add_entry("dirty set5 way0", 1'b1, 32'h02C, 32'h5555_AAAA, '0, 1'b0);
    add_entry("dirty set5 way1", 1'b1, 32'h06C, 32'h7777_0001, '0, 1'b0);
    add_entry("set5 way0 hit",   1'b0, 32'h02C, '0, 32'h5555_AAAA, 1'b1);
    add_entry("set5 way1 hit",   1'b0, 32'h068, '0, mem_rule(32'h068), 1'b1);
  endtask

  // one request, held until dhit is seen at a rising edge
  task automatic run_entry(input int i);
    dcache_geom_pkg::word_t got;
    @(negedge CLK);
    dmemREN   = !t_write[i];
    dmemWEN   = t_write[i];
    dmemaddr  = t_addr[i];
    dmemstore = t_data[i];
    bus_seen  = 1'b0;
    @(posedge CLK);
    while (!dhit) @(posedge CLK);
    got = dmemload;  // value the DUT presents at the accepting edge
    @(negedge CLK);
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    if (!t_write[i]) check_value(t_name[i], t_exp[i], got);
    check_value({t_name[i], " bus cycle"}, {31'd0, !t_nobus[i]}, {31'd0, bus_seen});
    if (t_write[i]) shadow[word_index(t_addr[i])] = t_data[i];
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run hung waiting for the DUT", cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    nRST         = 1'b0;
    dmemREN      = 1'b0;
    dmemWEN      = 1'b0;
    halt         = 1'b0;
    dmemaddr     = '0;
    dmemstore    = '0;
    bus_seen     = 1'b0;
    flush_writes = 0;
    errors       = 0;
    checks       = 0;
    n_fill       = 0;
    for (int i = 0; i < MEM_WORDS; i++) shadow[i] = mem_rule(i << 2);
    build_table();

    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    check_value("wb_cyc after reset", 32'd0, {31'd0, wb_cyc});
    check_value("wb_stb after reset", 32'd0, {31'd0, wb_stb});
    check_value("wb_we after reset", 32'd0, {31'd0, wb_we});
    check_value("flushed after reset", 32'd0, {31'd0, flushed});

    for (int i = 0; i < N_ENTRIES; i++) run_entry(i);

    // flush, every dirty line goes out and the array empties
    @(negedge CLK);
    halt = 1'b1;
    @(posedge CLK);
    while (!flushed) @(posedge CLK);
    @(negedge CLK);
    check_value("flush write count", FLUSH_WRITES, flush_writes);
    repeat (3) @(negedge CLK);
    check_value("flushed held", 32'd1, {31'd0, flushed});
    check_value("bus idle when flushed", 32'd0, {31'd0, wb_cyc});
    check_value("stb idle when flushed", 32'd0, {31'd0, wb_stb});

    // array is empty, a block cached before the flush no longer hits
    dmemREN  = 1'b1;
    dmemaddr = 32'h02C;
    @(posedge CLK);
    check_value("hit after flush", 32'd0, {31'd0, dhit});
    @(negedge CLK);
    dmemREN = 1'b0;

    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value($sformatf("memory word 0x%03h", i << 2), shadow[i], u_mem.mem[i]);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dcache.f
+incdir+common
common/dcache_geom_pkg.sv
common/dcache_ctrl_pkg.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
dcache/dcache.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - common

sources:
  - common/dcache_geom_pkg.sv
  - common/dcache_ctrl_pkg.sv
  - dcache/dcache_array.sv
  - dcache/dcache_ctrl.sv
  - dcache/dcache.sv
  - target: test
    files:
      - sim/dcache_mem_model.sv
      - sim/dcache_tb.sv
